/* source/hub_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hub bus definitions: widths, access size codes and the two-view address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hub_bus_pkg;

    localparam int ADDR_W       = 11;
    localparam int DATA_W       = 32;
    localparam int BYTE_W       = 8;
    localparam int SIZE_W       = 2;
    localparam int USER_OFS_W   = 6;
    localparam int SIMPLE_OFS_W = 4;

    // Size codes carried on the write and read request lines
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'b00;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'b10;
    localparam logic [SIZE_W-1:0] SIZE_NONE = 2'b11;

    // Bit 10 picks the view: clear for 64-byte user slots, set for
    // 16-byte simple slots
    typedef union packed {
        struct packed {
            logic                              space;
            logic [ADDR_W-USER_OFS_W-2:0]      slot;
            logic [USER_OFS_W-1:0]             offset;
        } user;
        struct packed {
            logic                              space;
            logic [ADDR_W-SIMPLE_OFS_W-6:0]    unused;
            logic [3:0]                        slot;
            logic [SIMPLE_OFS_W-1:0]           offset;
        } simple;
    } bus_addr_t;

endpackage

/* source/hub_map_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Hub memory map: slot numbers, GPIO register layout and select codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hub_map_pkg;

    // Slots per address space
    localparam int N_SLOTS = 16;
    localparam int SLOT_W  = $clog2(N_SLOTS);

    localparam int N_PINS = 8;
    localparam int PIN_W  = $clog2(N_PINS);

    // Implemented byte-register slots, anything up to N_SLOTS
    localparam int N_SIMPLE = 4;

    localparam logic [SLOT_W-1:0] SLOT_GPIO = 4'd1;

    // GPIO register offsets inside its user slot
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    // Pin n select sits at FSEL_BASE_OFS + 4*n
    localparam logic [5:0] FSEL_BASE_OFS = 6'h20;

    // Function select: top bit picks simple space, low bits the slot
    localparam int FSEL_W = 5;

    localparam logic [FSEL_W-1:0] FSEL_RESET = {1'b0, SLOT_GPIO};

    // Output register offset inside a simple slot
    localparam logic [3:0] BYTE_OUT_OFS = 4'h0;

endpackage

/* source/bus_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decode: slot select and gated write strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_decode (
    input  hub_bus_pkg::bus_addr_t            i_addr,
    input  logic [hub_bus_pkg::SIZE_W-1:0]    i_write_n,

    output logic                              o_simple,
    output logic [hub_map_pkg::SLOT_W-1:0]    o_slot,
    output logic                              o_gpio_we,
    output logic                              o_byte_we
);

    logic write_req;

    assign write_req = (i_write_n != hub_bus_pkg::SIZE_NONE);

    // Space bit sits in the same place in both views
    assign o_simple = i_addr.user.space;

    always_comb begin
        if (o_simple) begin
            o_slot = i_addr.simple.slot;
        end else begin
            o_slot = i_addr.user.slot;
        end
    end

    // GPIO lives in one user slot
    assign o_gpio_we = write_req && !o_simple && (o_slot == hub_map_pkg::SLOT_GPIO);

    // Writes to simple slots beyond the bank are dropped here
    assign o_byte_we = write_req && o_simple && (int'(o_slot) < hub_map_pkg::N_SIMPLE);

endmodule

/* source/gpio_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO block: output register, input readback and per-pin function selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gpio_regs (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic                                   i_we,
    input  logic [hub_bus_pkg::USER_OFS_W-1:0]     i_offset,
    input  logic [hub_bus_pkg::BYTE_W-1:0]         i_wdata,
    input  logic [hub_map_pkg::N_PINS-1:0]         i_ui,

    output logic [hub_bus_pkg::DATA_W-1:0]         o_rdata,
    output logic [hub_bus_pkg::BYTE_W-1:0]         o_gpio_out,
    output logic [hub_map_pkg::N_PINS-1:0][hub_map_pkg::FSEL_W-1:0] o_fsel
);

    logic [hub_bus_pkg::USER_OFS_W-1:0] fsel_rel;
    logic [hub_map_pkg::PIN_W-1:0]      fsel_idx;
    logic                               fsel_hit;

    // Word-aligned offsets from the select base map to one pin each
    assign fsel_rel = i_offset - hub_map_pkg::FSEL_BASE_OFS;
    assign fsel_idx = fsel_rel[hub_map_pkg::PIN_W+1:2];
    assign fsel_hit = (i_offset >= hub_map_pkg::FSEL_BASE_OFS)
                      && (fsel_rel[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            // Every pin starts out driven from the GPIO output register
            for (int n = 0; n < hub_map_pkg::N_PINS; n++) begin
                o_fsel[n] <= hub_map_pkg::FSEL_RESET;
            end
        end else if (i_we) begin
            if (i_offset == hub_map_pkg::GPIO_OUT_OFS) begin
                o_gpio_out <= i_wdata;
            end
            if (fsel_hit) begin
                o_fsel[fsel_idx] <= i_wdata[hub_map_pkg::FSEL_W-1:0];
            end
        end
    end

    // Read words are zero-extended, unknown offsets read zero
    always_comb begin
        o_rdata = '0;
        if (i_offset == hub_map_pkg::GPIO_OUT_OFS) begin
            o_rdata[hub_bus_pkg::BYTE_W-1:0] = o_gpio_out;
        end else if (i_offset == hub_map_pkg::GPIO_IN_OFS) begin
            o_rdata[hub_map_pkg::N_PINS-1:0] = i_ui;
        end else if (fsel_hit) begin
            o_rdata[hub_map_pkg::FSEL_W-1:0] = o_fsel[fsel_idx];
        end
    end

endmodule

/* source/byte_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Simple-slot bank: one byte output register per implemented slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module byte_regs (
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic                                   i_we,
    input  logic [hub_map_pkg::SLOT_W-1:0]         i_slot,
    input  logic [hub_bus_pkg::SIMPLE_OFS_W-1:0]   i_offset,
    input  logic [hub_bus_pkg::BYTE_W-1:0]         i_wdata,

    output logic [hub_bus_pkg::BYTE_W-1:0]         o_rdata,
    output logic [hub_map_pkg::N_SIMPLE-1:0][hub_bus_pkg::BYTE_W-1:0] o_outs
);

    logic ofs_hit;

    assign ofs_hit = (i_offset == hub_map_pkg::BYTE_OUT_OFS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_outs <= '0;
        end else if (i_we && ofs_hit) begin
            // Slot range is already checked by the write strobe
            for (int s = 0; s < hub_map_pkg::N_SIMPLE; s++) begin
                if (int'(i_slot) == s) begin
                    o_outs[s] <= i_wdata;
                end
            end
        end
    end

    // Unimplemented slots and other offsets read back as zero
    always_comb begin
        o_rdata = '0;
        if (ofs_hit) begin
            for (int s = 0; s < hub_map_pkg::N_SIMPLE; s++) begin
                if (int'(i_slot) == s) begin
                    o_rdata = o_outs[s];
                end
            end
        end
    end

endmodule

/* source/pin_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output pin mux: each pin follows the slot named by its function select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pin_mux (
    input  logic [hub_map_pkg::N_PINS-1:0][hub_map_pkg::FSEL_W-1:0]   i_fsel,
    input  logic [hub_bus_pkg::BYTE_W-1:0]                            i_gpio_out,
    input  logic [hub_map_pkg::N_SIMPLE-1:0][hub_bus_pkg::BYTE_W-1:0] i_simple_outs,

    output logic [hub_map_pkg::N_PINS-1:0]                            o_pins
);

    // Output words seen in each space, zero where nothing is fitted
    logic [hub_bus_pkg::BYTE_W-1:0] user_word   [hub_map_pkg::N_SLOTS];
    logic [hub_bus_pkg::BYTE_W-1:0] simple_word [hub_map_pkg::N_SLOTS];

    always_comb begin
        for (int s = 0; s < hub_map_pkg::N_SLOTS; s++) begin
            user_word[s]   = '0;
            simple_word[s] = '0;
        end
        user_word[hub_map_pkg::SLOT_GPIO] = i_gpio_out;
        for (int s = 0; s < hub_map_pkg::N_SIMPLE; s++) begin
            simple_word[s] = i_simple_outs[s];
        end
    end

    always_comb begin
        for (int n = 0; n < hub_map_pkg::N_PINS; n++) begin
            // Pin n always takes bit n of the chosen word
            if (i_fsel[n][hub_map_pkg::FSEL_W-1]) begin
                o_pins[n] = simple_word[i_fsel[n][hub_map_pkg::SLOT_W-1:0]][n];
            end else begin
                o_pins[n] = user_word[i_fsel[n][hub_map_pkg::SLOT_W-1:0]][n];
            end
        end
    end

endmodule

/* source/read_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read path: slot data select, registered read data and ready with hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module read_capture (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [hub_bus_pkg::SIZE_W-1:0]      i_read_n,
    input  logic [hub_bus_pkg::SIZE_W-1:0]      i_write_n,
    input  logic                                i_read_complete,
    input  logic                                i_simple,
    input  logic [hub_map_pkg::SLOT_W-1:0]      i_slot,
    input  logic [hub_bus_pkg::DATA_W-1:0]      i_gpio_rdata,
    input  logic [hub_bus_pkg::BYTE_W-1:0]      i_byte_rdata,

    output logic [hub_bus_pkg::DATA_W-1:0]      o_rdata,
    output logic                                o_ready
);

    logic                           read_req;
    logic                           hold;
    logic                           ready_r;
    logic [hub_bus_pkg::DATA_W-1:0] sel_word;

    assign read_req = (i_read_n != hub_bus_pkg::SIZE_NONE);

    // Empty user slots return zero
    always_comb begin
        sel_word = '0;
        if (i_simple) begin
            sel_word[hub_bus_pkg::BYTE_W-1:0] = i_byte_rdata;
        end else if (i_slot == hub_map_pkg::SLOT_GPIO) begin
            sel_word = i_gpio_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (read_req && !hold) begin
                hold <= 1'b1;
            end
            // Every slot answers in one cycle
            ready_r <= read_req;
        end
    end

    // Held data stays put until the core completes the read
    always_ff @(posedge clk) begin
        if (read_req && !hold) begin
            o_rdata <= sel_word;
        end
    end

    assign o_ready = ready_r || (i_write_n != hub_bus_pkg::SIZE_NONE);

endmodule

/* source/peripheral_hub.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral hub top: decode, GPIO, byte registers, pin mux and read path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module peripheral_hub (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [hub_map_pkg::N_PINS-1:0]      i_ui,
    input  hub_bus_pkg::bus_addr_t              i_addr,
    input  logic [hub_bus_pkg::DATA_W-1:0]      i_wdata,
    input  logic [hub_bus_pkg::SIZE_W-1:0]      i_write_n,
    input  logic [hub_bus_pkg::SIZE_W-1:0]      i_read_n,
    input  logic                                i_read_complete,

    output logic [hub_map_pkg::N_PINS-1:0]      o_pins,
    output logic [hub_bus_pkg::DATA_W-1:0]      o_rdata,
    output logic                                o_ready
);

    logic                                   addr_simple;
    logic [hub_map_pkg::SLOT_W-1:0]         addr_slot;
    logic                                   gpio_we;
    logic                                   byte_we;

    logic [hub_bus_pkg::DATA_W-1:0]         gpio_rdata;
    logic [hub_bus_pkg::BYTE_W-1:0]         byte_rdata;
    logic [hub_bus_pkg::BYTE_W-1:0]         gpio_out;

    logic [hub_map_pkg::N_PINS-1:0][hub_map_pkg::FSEL_W-1:0]     fsel;
    logic [hub_map_pkg::N_SIMPLE-1:0][hub_bus_pkg::BYTE_W-1:0]   simple_outs;

    bus_decode bus_decode_inst (
        .i_addr             (i_addr),
        .i_write_n          (i_write_n),
        .o_simple           (addr_simple),
        .o_slot             (addr_slot),
        .o_gpio_we          (gpio_we),
        .o_byte_we          (byte_we)
    );

    // Only the low byte of write data reaches the registers
    gpio_regs gpio_regs_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_we               (gpio_we),
        .i_offset           (i_addr.user.offset),
        .i_wdata            (i_wdata[hub_bus_pkg::BYTE_W-1:0]),
        .i_ui               (i_ui),
        .o_rdata            (gpio_rdata),
        .o_gpio_out         (gpio_out),
        .o_fsel             (fsel)
    );

    byte_regs byte_regs_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_we               (byte_we),
        .i_slot             (addr_slot),
        .i_offset           (i_addr.simple.offset),
        .i_wdata            (i_wdata[hub_bus_pkg::BYTE_W-1:0]),
        .o_rdata            (byte_rdata),
        .o_outs             (simple_outs)
    );

    pin_mux pin_mux_inst (
        .i_fsel             (fsel),
        .i_gpio_out         (gpio_out),
        .i_simple_outs      (simple_outs),
        .o_pins             (o_pins)
    );

    read_capture read_capture_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_read_n           (i_read_n),
        .i_write_n          (i_write_n),
        .i_read_complete    (i_read_complete),
        .i_simple           (addr_simple),
        .i_slot             (addr_slot),
        .i_gpio_rdata       (gpio_rdata),
        .i_byte_rdata       (byte_rdata),
        .o_rdata            (o_rdata),
        .o_ready            (o_ready)
    );

endmodule

/* tests/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset: 40 ns clock, reset low for five cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release away from the edge so the DUT sees a clean synchronous reset
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2;
        o_rst_n = 1'b1;
    end

endmodule

/* tests/tb_peripheral_hub.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral hub testbench: table-driven bus traffic, pin and read checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_peripheral_hub;

    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_PINS  = 2'd2;
    localparam logic [1:0] OP_HOLD  = 2'd3;
    localparam int         NS       = hub_map_pkg::N_SIMPLE;

    // With use_model set, write data comes from the LFSR and the expected value from the model
    typedef struct packed {
        logic [1:0]  op;
        logic        use_model;
        logic [10:0] addr;
        logic [31:0] wdata;
        logic [7:0]  ui;
        logic [31:0] expected;
    } stim_t;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui;
    logic [10:0] i_addr;
    logic [31:0] i_wdata;
    logic [1:0]  i_write_n;
    logic [1:0]  i_read_n;
    logic        i_read_complete;
    logic [7:0]  o_pins;
    logic [31:0] o_rdata;
    logic        o_ready;

    stim_t       stim_q [$];
    logic [31:0] lfsr_state    = 32'h24c;
    int          check_cnt     = 0;
    int          err_cnt       = 0;
    int          cycle_cnt     = 0;
    int          timeout_limit = 1000;

    // Reference model of the hub registers
    logic [7:0]  model_gpio;
    logic [4:0]  model_fsel [8];
    logic [7:0]  model_byte [16];

    tb_clock_gen clock_gen_inst (
        .o_clk              (clk),
        .o_rst_n            (rst_n)
    );

    peripheral_hub peripheral_hub_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_ui               (i_ui),
        .i_addr             (i_addr),
        .i_wdata            (i_wdata),
        .i_write_n          (i_write_n),
        .i_read_n           (i_read_n),
        .i_read_complete    (i_read_complete),
        .o_pins             (o_pins),
        .o_rdata            (o_rdata),
        .o_ready            (o_ready)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, the test table did not finish", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [10:0] user_addr(input logic [3:0] slot, input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [10:0] simple_addr(input logic [3:0] slot, input logic [3:0] ofs);
        return {1'b1, 2'b00, slot, ofs};
    endfunction

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'h8020_0003;
        end
        return nxt;
    endfunction

    task automatic take_rand_byte(output logic [7:0] value);
        value = 8'h00;
        for (int b = 0; b < 8; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic model_write(input logic [10:0] addr, input logic [7:0] data);
        logic [5:0] ofs;
        ofs = addr[5:0];
        if (addr[10]) begin
            if (addr[3:0] == hub_map_pkg::BYTE_OUT_OFS && int'(addr[7:4]) < NS) begin
                model_byte[addr[7:4]] = data;
            end
        end else if (addr[9:6] == hub_map_pkg::SLOT_GPIO) begin
            if (ofs == hub_map_pkg::GPIO_OUT_OFS) begin
                model_gpio = data;
            end else if (ofs >= hub_map_pkg::FSEL_BASE_OFS && ofs[1:0] == 2'b00) begin
                model_fsel[ofs[4:2]] = data[4:0];
            end
        end
    endtask

    function automatic logic [31:0] model_read(input logic [10:0] addr, input logic [7:0] ui);
        logic [31:0] word;
        logic [5:0]  ofs;
        word = 32'h0;
        ofs  = addr[5:0];
        if (addr[10]) begin
            if (addr[3:0] == hub_map_pkg::BYTE_OUT_OFS && int'(addr[7:4]) < NS) begin
                word[7:0] = model_byte[addr[7:4]];
            end
        end else if (addr[9:6] == hub_map_pkg::SLOT_GPIO) begin
            if (ofs == hub_map_pkg::GPIO_OUT_OFS) begin
                word[7:0] = model_gpio;
            end else if (ofs == hub_map_pkg::GPIO_IN_OFS) begin
                word[7:0] = ui;
            end else if (ofs >= hub_map_pkg::FSEL_BASE_OFS && ofs[1:0] == 2'b00) begin
                word[4:0] = model_fsel[ofs[4:2]];
            end
        end
        return word;
    endfunction

    // Pin n shows bit n of the slot its select names, empty slots give 0
    function automatic logic [7:0] model_pins();
        logic [7:0] pins;
        logic [4:0] code;
        pins = 8'h00;
        for (int n = 0; n < 8; n++) begin
            code = model_fsel[n];
            if (code[4]) begin
                if (int'(code[3:0]) < NS) begin
                    pins[n] = model_byte[code[3:0]][n];
                end
            end else if (code[3:0] == 4'd1) begin
                pins[n] = model_gpio[n];
            end
        end
        return pins;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        err_cnt++;
        $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
    endtask

    task automatic add_entry(input logic [1:0] op, input logic use_model,
                             input logic [10:0] addr, input logic [31:0] wdata,
                             input logic [7:0] ui, input logic [31:0] expected);
        stim_t e;
        e.op        = op;
        e.use_model = use_model;
        e.addr      = addr;
        e.wdata     = wdata;
        e.ui        = ui;
        e.expected  = expected;
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        logic [10:0] out_a;
        logic [10:0] in_a;
        out_a = user_addr(hub_map_pkg::SLOT_GPIO, hub_map_pkg::GPIO_OUT_OFS);
        in_a  = user_addr(hub_map_pkg::SLOT_GPIO, hub_map_pkg::GPIO_IN_OFS);
        // Reset state: every select is the GPIO code and the pins are low
        for (int n = 0; n < 8; n++) begin
            add_entry(OP_READ, 1'b0, user_addr(hub_map_pkg::SLOT_GPIO,
                      hub_map_pkg::FSEL_BASE_OFS + 6'(4 * n)), 32'h0, 8'h00, 32'h1);
        end
        add_entry(OP_PINS, 1'b0, 11'h0, 32'h0, 8'h00, 32'h0);
        // GPIO output and input readback
        add_entry(OP_WRITE, 1'b0, out_a, 32'h0000_00a5, 8'h00, 32'h0);
        add_entry(OP_PINS,  1'b0, 11'h0, 32'h0, 8'h00, 32'ha5);
        add_entry(OP_READ,  1'b0, out_a, 32'h0, 8'h00, 32'ha5);
        add_entry(OP_READ,  1'b0, in_a, 32'h0, 8'h3c, 32'h3c);
        add_entry(OP_WRITE, 1'b0, out_a, 32'h1234_565a, 8'h00, 32'h0);
        add_entry(OP_READ,  1'b0, out_a, 32'h0, 8'h00, 32'h5a);
        // Byte registers, other offsets and empty simple slots
        for (int s = 0; s < NS; s++) begin
            add_entry(OP_WRITE, 1'b1, simple_addr(4'(s), 4'h0), 32'h0, 8'h00, 32'h0);
        end
        for (int s = 0; s < NS; s++) begin
            add_entry(OP_READ, 1'b1, simple_addr(4'(s), 4'h0), 32'h0, 8'h00, 32'h0);
        end
        add_entry(OP_READ,  1'b0, simple_addr(4'd0, 4'h4), 32'h0, 8'h00, 32'h0);
        add_entry(OP_WRITE, 1'b1, simple_addr(4'(NS), 4'h0), 32'h0, 8'h00, 32'h0);
        add_entry(OP_READ,  1'b0, simple_addr(4'(NS), 4'h0), 32'h0, 8'h00, 32'h0);
        add_entry(OP_READ,  1'b0, simple_addr(4'd15, 4'h0), 32'h0, 8'h00, 32'h0);
        // Remap every pin onto a byte register
        for (int n = 0; n < 8; n++) begin
            add_entry(OP_WRITE, 1'b0, user_addr(hub_map_pkg::SLOT_GPIO,
                      hub_map_pkg::FSEL_BASE_OFS + 6'(4 * n)),
                      {27'h0, 1'b1, 4'(n % NS)}, 8'h00, 32'h0);
        end
        add_entry(OP_PINS, 1'b1, 11'h0, 32'h0, 8'h00, 32'h0);
        for (int s = 0; s < NS; s++) begin
            add_entry(OP_WRITE, 1'b1, simple_addr(4'(s), 4'h0), 32'h0, 8'h00, 32'h0);
        end
        add_entry(OP_PINS, 1'b1, 11'h0, 32'h0, 8'h00, 32'h0);
        // Pin 7 onto an empty user slot, pin 6 onto an empty simple slot
        add_entry(OP_WRITE, 1'b0, user_addr(hub_map_pkg::SLOT_GPIO, 6'h3c), 32'h05, 8'h00, 32'h0);
        add_entry(OP_WRITE, 1'b0, user_addr(hub_map_pkg::SLOT_GPIO, 6'h38), 32'h19, 8'h00, 32'h0);
        add_entry(OP_PINS, 1'b1, 11'h0, 32'h0, 8'h00, 32'h0);
        add_entry(OP_READ, 1'b1, user_addr(hub_map_pkg::SLOT_GPIO, 6'h28), 32'h0, 8'h00, 32'h0);
        // Empty user slots read zero and still answer
        add_entry(OP_READ, 1'b0, user_addr(4'd0, 6'h00), 32'h0, 8'hff, 32'h0);
        add_entry(OP_READ, 1'b0, user_addr(4'd0, 6'h04), 32'h0, 8'hff, 32'h0);
        add_entry(OP_READ, 1'b0, user_addr(4'd2, 6'h00), 32'h0, 8'hff, 32'h0);
        add_entry(OP_READ, 1'b0, user_addr(4'd15, 6'h20), 32'h0, 8'hff, 32'h0);
        // Held read data, then fresh data
        add_entry(OP_HOLD, 1'b1, simple_addr(4'd1, 4'h0), 32'h77, 8'h00, 32'h0);
        add_entry(OP_READ, 1'b1, simple_addr(4'd1, 4'h0), 32'h0, 8'h00, 32'h0);
        add_entry(OP_HOLD, 1'b1, out_a, 32'h3e, 8'h00, 32'h0);
        add_entry(OP_READ, 1'b1, out_a, 32'h0, 8'h00, 32'h0);
        add_entry(OP_PINS, 1'b1, 11'h0, 32'h0, 8'h00, 32'h0);
    endtask

    // Tasks below start and end 2 ns after a rising edge
    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data);
        i_addr    = addr;
        i_wdata   = data;
        i_write_n = hub_bus_pkg::SIZE_WORD;
        #1;
        check_cnt++;
        if (o_ready !== 1'b1) report_mismatch("o_ready", 32'(o_ready), 32'h1);
        @(posedge clk);
        #2;
        i_write_n = hub_bus_pkg::SIZE_NONE;
        model_write(addr, data[7:0]);
    endtask

    task automatic bus_read(input logic [10:0] addr, input logic [31:0] want,
                            input logic keep_hold);
        int cycles;
        i_addr   = addr;
        i_read_n = hub_bus_pkg::SIZE_WORD;
        #1;
        check_cnt++;
        if (o_ready !== 1'b0) report_mismatch("o_ready", 32'(o_ready), 32'h0);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (o_ready !== 1'b1 && cycles < 4);
        check_cnt++;
        if (o_ready !== 1'b1) begin
            err_cnt++;
            $display("Read at address 0x%03h got no ready within %0d cycles", addr, cycles);
        end else if (cycles != 1) begin
            err_cnt++;
            $display("Read at address 0x%03h was ready after %0d cycles, not 1", addr, cycles);
        end
        check_cnt++;
        if (o_rdata !== want) report_mismatch("o_rdata", o_rdata, want);
        #1;
        i_read_n        = hub_bus_pkg::SIZE_NONE;
        i_read_complete = !keep_hold;
        @(posedge clk);
        #2;
        i_read_complete = 1'b0;
    endtask

    // Change the register and the address while the read is still held
    task automatic hold_read(input logic [10:0] addr, input logic [31:0] new_data,
                             input logic [31:0] want);
        bus_read(addr, want, 1'b1);
        bus_write(addr, new_data);
        i_addr   = user_addr(hub_map_pkg::SLOT_GPIO, hub_map_pkg::GPIO_IN_OFS);
        i_ui     = 8'hc3;
        i_read_n = hub_bus_pkg::SIZE_WORD;
        @(posedge clk);
        #1;
        check_cnt++;
        if (o_rdata !== want) report_mismatch("o_rdata", o_rdata, want);
        #1;
        i_read_n        = hub_bus_pkg::SIZE_NONE;
        i_read_complete = 1'b1;
        @(posedge clk);
        #1;
        check_cnt++;
        if (o_rdata !== want) report_mismatch("o_rdata", o_rdata, want);
        #1;
        i_read_complete = 1'b0;
    endtask

    task automatic apply_entry(input stim_t e);
        logic [31:0] want;
        logic [31:0] data;
        logic [7:0]  rnd;
        i_ui = e.ui;
        case (e.op)
            OP_WRITE: begin
                data = e.wdata;
                if (e.use_model) begin
                    take_rand_byte(rnd);
                    data = {24'h0, rnd};
                end
                bus_write(e.addr, data);
            end
            OP_READ: begin
                want = e.use_model ? model_read(e.addr, e.ui) : e.expected;
                bus_read(e.addr, want, 1'b0);
            end
            OP_PINS: begin
                want = e.use_model ? {24'h0, model_pins()} : e.expected;
                #1;
                check_cnt++;
                if (o_pins !== want[7:0]) report_mismatch("o_pins", 32'(o_pins), want);
                @(posedge clk);
                #2;
            end
            default: begin
                want = e.use_model ? model_read(e.addr, e.ui) : e.expected;
                hold_read(e.addr, e.wdata, want);
            end
        endcase
    endtask

    initial begin
        i_ui            = 8'h00;
        i_addr          = 11'h0;
        i_wdata         = 32'h0;
        i_write_n       = hub_bus_pkg::SIZE_NONE;
        i_read_n        = hub_bus_pkg::SIZE_NONE;
        i_read_complete = 1'b0;
        model_gpio      = 8'h00;
        for (int n = 0; n < 8; n++) begin
            model_fsel[n] = 5'h01;
        end
        for (int s = 0; s < 16; s++) begin
            model_byte[s] = 8'h00;
        end
        build_table();
        timeout_limit = stim_q.size() * 8 + 20;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end
        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/hub_bus_pkg.sv
source/hub_map_pkg.sv
source/bus_decode.sv
source/gpio_regs.sv
source/byte_regs.sv
source/pin_mux.sv
source/read_capture.sv
source/peripheral_hub.sv
tests/tb_clock_gen.sv
tests/tb_peripheral_hub.sv

/* Makefile */
# Verilator lint and simulation for the peripheral hub

VERILATOR ?= verilator
TOP       ?= tb_peripheral_hub
RTL_TOP   ?= peripheral_hub
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
